// File: axi2apb_pkg.sv
// Bridge widths, queue depth and entry sizes, burst/phase/response enums, response ranking
package axi2apb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int id_w       = 4;
    localparam int axi_data_w = 64;
    localparam int apb_data_w = 32;
    localparam int addr_w     = 32;
    localparam int len_w      = 8;
    localparam int strb_w     = axi_data_w / 8;
    localparam int apb_strb_w = apb_data_w / 8;

    // Queue geometry
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    // Packed queue entries
    localparam int ar_entry_w = id_w + len_w + 2 + addr_w;
    localparam int w_entry_w  = strb_w + axi_data_w;
    localparam int r_entry_w  = id_w + axi_data_w + 2 + 1;
    localparam int b_entry_w  = id_w + 2;

    // Encoding 2'b11 is reserved and walks like fixed
    typedef enum logic [1:0] {
        burst_fixed = 2'd0,
        burst_incr  = 2'd1,
        burst_wrap  = 2'd2
    } burst_e;

    typedef enum logic [2:0] {
        ph_idle,
        ph_lo_setup,
        ph_lo_access,
        ph_hi_setup,
        ph_hi_access
    } apb_phase_e;

    // Encodings rise with severity
    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_exokay = 2'd1,
        resp_slverr = 2'd2,
        resp_decerr = 2'd3
    } resp_e;

    function automatic resp_e worst_resp(input resp_e a, input resp_e b);
        return (a > b) ? a : b;
    endfunction

endpackage

// File: bridge_fifo.sv
// Synchronous first-word-fall-through FIFO with configurable entry width
module bridge_fifo import axi2apb_pkg::*; #(
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [width-1:0] din,
    input  logic             pop,
    output logic [width-1:0] dout,
    output logic             empty,
    output logic             full
);

    logic [width-1:0]      mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    function automatic logic [fifo_ptr_w-1:0] ptr_next(input logic [fifo_ptr_w-1:0] p);
        if (p == fifo_ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == fifo_cnt_w'(fifo_depth));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: bridge_ifs.sv
// Burst command and beat response interfaces between the bridge stages
interface burst_cmd_if import axi2apb_pkg::*; ();

    logic                  valid;
    logic                  is_write;
    logic [id_w-1:0]       id;
    logic [addr_w-1:0]     addr;
    logic [len_w-1:0]      len;
    burst_e                burst;
    logic [axi_data_w-1:0] wdata;
    logic [strb_w-1:0]     wstrb;
    logic                  w_avail;
    logic                  take;
    logic                  wpop;

    modport source (
        output valid, is_write, id, addr, len, burst, wdata, wstrb, w_avail,
        input  take, wpop
    );

    modport sink (
        input  valid, is_write, id, addr, len, burst, wdata, wstrb, w_avail,
        output take, wpop
    );

endinterface

interface beat_resp_if import axi2apb_pkg::*; ();

    logic                  r_push;
    logic [id_w-1:0]       rid;
    logic [axi_data_w-1:0] rdata;
    resp_e                 rresp;
    logic                  rlast;
    logic                  r_full;
    logic                  b_push;
    logic [id_w-1:0]       bid;
    resp_e                 bresp;
    logic                  b_full;

    modport source (
        output r_push, rid, rdata, rresp, rlast, b_push, bid, bresp,
        input  r_full, b_full
    );

    modport sink (
        input  r_push, rid, rdata, rresp, rlast, b_push, bid, bresp,
        output r_full, b_full
    );

endinterface

// File: axi_req_capture.sv
// AR, AW and W request queues with read-first burst selection
module axi_req_capture import axi2apb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [addr_w-1:0]     araddr,
    input  logic [id_w-1:0]       arid,
    input  logic [len_w-1:0]      arlen,
    input  logic [1:0]            arburst,
    input  logic [2:0]            arsize,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_w-1:0]     awaddr,
    input  logic [id_w-1:0]       awid,
    input  logic [len_w-1:0]      awlen,
    input  logic [1:0]            awburst,
    input  logic [2:0]            awsize,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [axi_data_w-1:0] wdata,
    input  logic [strb_w-1:0]     wstrb,
    input  logic                  wlast,
    input  logic                  wvalid,
    output logic                  wready,
    burst_cmd_if.source           cmd
);

    logic                  ar_empty, ar_full;
    logic                  aw_empty, aw_full;
    logic                  w_empty, w_full;
    logic [ar_entry_w-1:0] ar_head, aw_head;
    logic [w_entry_w-1:0]  w_head;
    logic [id_w-1:0]       hd_id;
    logic [len_w-1:0]      hd_len;
    logic [1:0]            hd_burst;
    logic [addr_w-1:0]     hd_addr;
    logic                  busy, busy_write, pick_write;

    assign arready = !ar_full;
    assign awready = !aw_full;
    assign wready  = !w_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request queues
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bridge_fifo #(.width(ar_entry_w)) ar_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(arvalid && arready), .din({arid, arlen, arburst, araddr}),
        .pop(cmd.take && !busy_write), .dout(ar_head),
        .empty(ar_empty), .full(ar_full)
    );

    bridge_fifo #(.width(ar_entry_w)) aw_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(awvalid && awready), .din({awid, awlen, awburst, awaddr}),
        .pop(cmd.take && busy_write), .dout(aw_head),
        .empty(aw_empty), .full(aw_full)
    );

    bridge_fifo #(.width(w_entry_w)) w_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(wvalid && wready), .din({wstrb, wdata}),
        .pop(cmd.wpop), .dout(w_head),
        .empty(w_empty), .full(w_full)
    );

    // Reads win while unlocked, then the choice holds until take
    assign pick_write = busy ? busy_write : ar_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            busy_write <= 1'b0;
        end else if (cmd.take) begin
            busy <= 1'b0;
        end else if (!busy && cmd.valid) begin
            busy       <= 1'b1;
            busy_write <= pick_write;
        end
    end

    assign {hd_id, hd_len, hd_burst, hd_addr} = pick_write ? aw_head : ar_head;

    assign cmd.valid    = busy || !ar_empty || !aw_empty;
    assign cmd.is_write = pick_write;
    assign cmd.id       = hd_id;
    assign cmd.len      = hd_len;
    assign cmd.burst    = burst_e'(hd_burst);
    // Read bursts start on a 64-bit boundary
    assign cmd.addr     = pick_write ? hd_addr : {hd_addr[addr_w-1:3], 3'b000};
    assign cmd.wdata    = w_head[axi_data_w-1:0];
    assign cmd.wstrb    = w_head[w_entry_w-1:axi_data_w];
    assign cmd.w_avail  = !w_empty;

endmodule

// File: apb_beat_engine.sv
// Burst address generator and APB phase machine for split 64-bit beats
module apb_beat_engine import axi2apb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    burst_cmd_if.sink             cmd,
    beat_resp_if.source           resp,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [addr_w-1:0]     paddr,
    output logic [apb_data_w-1:0] pwdata,
    output logic [apb_strb_w-1:0] pstrb,
    input  logic                  pready,
    input  logic [1:0]            presp,
    input  logic [apb_data_w-1:0] prdata
);

    apb_phase_e            state;
    logic                  active;
    logic                  dir_wr;
    logic [addr_w-1:0]     beat_addr;
    logic [addr_w-1:0]     next_addr;
    logic [addr_w-1:0]     wrap_mask;
    logic [len_w-1:0]      beats_left;
    resp_e                 acc_resp;
    resp_e                 pslv_resp;
    logic [apb_data_w-1:0] lo_rdata;
    logic                  hi_phase, last_beat, beat_go, lo_done, beat_done;

    assign pslv_resp = resp_e'(presp);
    assign hi_phase  = (state == ph_hi_setup) || (state == ph_hi_access);
    assign last_beat = (beats_left == '0);
    assign lo_done   = (state == ph_lo_access) && pready;
    assign beat_done = (state == ph_hi_access) && pready;
    assign beat_go   = (state == ph_idle) && active && (dir_wr ? cmd.w_avail : !resp.r_full);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beat address sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wrap window spans 8 bytes per beat of the burst
    assign wrap_mask = ((addr_w'(cmd.len) + 1'b1) << 3) - 1'b1;

    always_comb begin
        case (cmd.burst)
            burst_incr: next_addr = beat_addr + addr_w'(8);
            burst_wrap: next_addr = (beat_addr & ~wrap_mask) |
                                    ((beat_addr + addr_w'(8)) & wrap_mask);
            default:    next_addr = beat_addr;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB phases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ph_idle;
            active     <= 1'b0;
            dir_wr     <= 1'b0;
            beat_addr  <= '0;
            beats_left <= '0;
            acc_resp   <= resp_okay;
        end else begin
            case (state)
                ph_idle: begin
                    // A write burst waits for room in the B queue
                    if (!active && cmd.valid && (!cmd.is_write || !resp.b_full)) begin
                        active     <= 1'b1;
                        dir_wr     <= cmd.is_write;
                        beat_addr  <= cmd.addr;
                        beats_left <= cmd.len;
                        acc_resp   <= resp_okay;
                    end else if (beat_go) begin
                        state <= ph_lo_setup;
                    end
                end
                ph_lo_setup: state <= ph_lo_access;
                ph_lo_access: begin
                    if (pready) begin
                        state <= ph_hi_setup;
                        if (dir_wr) begin
                            acc_resp <= worst_resp(acc_resp, pslv_resp);
                        end
                    end
                end
                ph_hi_setup: state <= ph_hi_access;
                ph_hi_access: begin
                    if (pready) begin
                        state <= ph_idle;
                        if (dir_wr) begin
                            acc_resp <= worst_resp(acc_resp, pslv_resp);
                        end
                        if (last_beat) begin
                            active <= 1'b0;
                        end else begin
                            beats_left <= beats_left - 1'b1;
                            beat_addr  <= next_addr;
                        end
                    end
                end
                default: state <= ph_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lo_done) begin
            lo_rdata <= prdata;
        end
    end

    assign psel    = (state != ph_idle);
    assign penable = (state == ph_lo_access) || (state == ph_hi_access);
    assign pwrite  = psel && dir_wr;
    assign paddr   = hi_phase ? beat_addr + addr_w'(4) : beat_addr;
    assign pwdata  = hi_phase ? cmd.wdata[axi_data_w-1:apb_data_w] : cmd.wdata[apb_data_w-1:0];
    assign pstrb   = !dir_wr ? '0 :
                     hi_phase ? cmd.wstrb[strb_w-1:apb_strb_w] : cmd.wstrb[apb_strb_w-1:0];

    assign resp.r_push = beat_done && !dir_wr;
    assign resp.rid    = cmd.id;
    assign resp.rdata  = {prdata, lo_rdata};
    assign resp.rresp  = pslv_resp;
    assign resp.rlast  = last_beat;
    assign resp.b_push = beat_done && dir_wr && last_beat;
    assign resp.bid    = cmd.id;
    assign resp.bresp  = worst_resp(acc_resp, pslv_resp);

    assign cmd.take = beat_done && last_beat;
    assign cmd.wpop = beat_done && dir_wr;

endmodule

// File: axi_resp_queue.sv
// R and B response queues feeding the AXI read-data and write-response channels
module axi_resp_queue import axi2apb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    beat_resp_if.sink             resp,
    output logic [id_w-1:0]       rid,
    output logic [axi_data_w-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rlast,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [id_w-1:0]       bid,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready
);

    logic                 r_empty;
    logic                 b_empty;
    logic [r_entry_w-1:0] r_head;
    logic [b_entry_w-1:0] b_head;

    bridge_fifo #(.width(r_entry_w)) r_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(resp.r_push), .din({resp.rid, resp.rdata, resp.rresp, resp.rlast}),
        .pop(rready && rvalid), .dout(r_head),
        .empty(r_empty), .full(resp.r_full)
    );

    bridge_fifo #(.width(b_entry_w)) b_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(resp.b_push), .din({resp.bid, resp.bresp}),
        .pop(bready && bvalid), .dout(b_head),
        .empty(b_empty), .full(resp.b_full)
    );

    // Queue heads go straight out as the AXI payload
    assign {rid, rdata, rresp, rlast} = r_head;
    assign {bid, bresp}               = b_head;
    assign rvalid = !r_empty;
    assign bvalid = !b_empty;

endmodule

// File: axi2apb_bridge.sv
// AXI slave to APB master bridge top level
module axi2apb_bridge import axi2apb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [id_w-1:0]       arid,
    input  logic [addr_w-1:0]     araddr,
    input  logic [len_w-1:0]      arlen,
    input  logic [2:0]            arsize,
    input  logic [1:0]            arburst,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [id_w-1:0]       rid,
    output logic [axi_data_w-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rlast,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic [id_w-1:0]       awid,
    input  logic [addr_w-1:0]     awaddr,
    input  logic [len_w-1:0]      awlen,
    input  logic [2:0]            awsize,
    input  logic [1:0]            awburst,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [axi_data_w-1:0] wdata,
    input  logic [strb_w-1:0]     wstrb,
    input  logic                  wlast,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [id_w-1:0]       bid,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [addr_w-1:0]     paddr,
    output logic [apb_data_w-1:0] pwdata,
    output logic [apb_strb_w-1:0] pstrb,
    input  logic                  pready,
    input  logic [1:0]            presp,
    input  logic [apb_data_w-1:0] prdata
);

    burst_cmd_if cmd_if ();
    beat_resp_if resp_if ();

    axi_req_capture capture_i (
        .clk(clk), .rst_n(rst_n),
        .araddr(araddr), .arid(arid), .arlen(arlen), .arburst(arburst),
        .arsize(arsize), .arvalid(arvalid), .arready(arready),
        .awaddr(awaddr), .awid(awid), .awlen(awlen), .awburst(awburst),
        .awsize(awsize), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .cmd(cmd_if.source)
    );

    apb_beat_engine engine_i (
        .clk(clk), .rst_n(rst_n),
        .cmd(cmd_if.sink), .resp(resp_if.source),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .presp(presp), .prdata(prdata)
    );

    axi_resp_queue resp_queue_i (
        .clk(clk), .rst_n(rst_n),
        .resp(resp_if.sink),
        .rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast),
        .rvalid(rvalid), .rready(rready),
        .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

endmodule

// File: axi2apb_asserts.sv
// APB phase and AXI response handshake assertions, bound into the bridge top level
module axi2apb_asserts import axi2apb_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              psel,
    input logic              penable,
    input logic              pready,
    input logic [addr_w-1:0] paddr,
    input logic              rvalid,
    input logic              rready,
    input logic              bvalid,
    input logic              bready
);

    penable_in_psel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
        else $error("penable high while psel is low");

    // Address holds from setup until the access completes
    paddr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && !(penable && pready)) |=> $stable(paddr))
        else $error("paddr changed inside an APB transfer");

    rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> rvalid)
        else $error("rvalid dropped before rready");

    bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule

bind axi2apb_bridge axi2apb_asserts asserts_i (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pready(pready),
    .paddr(paddr), .rvalid(rvalid), .rready(rready), .bvalid(bvalid), .bready(bready)
);

// File: tb_axi2apb.sv
// Testbench top with clock, reset, AXI master driver, APB slave model, reference model and checker
module tb_axi2apb import axi2apb_pkg::*; ();

    localparam logic [31:0] err_addr   = 32'h0000_0204;
    localparam logic [31:0] lcg_seed   = 32'd85;
    // Beats issued over all six tests
    localparam int          test_beats = 40;

    typedef struct packed {
        logic [id_w-1:0]       id;
        logic [axi_data_w-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } r_beat_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } b_resp_t;

    logic                  clk, rst_n;
    logic [id_w-1:0]       arid, awid, rid, bid;
    logic [addr_w-1:0]     araddr, awaddr, paddr;
    logic [len_w-1:0]      arlen, awlen;
    logic [2:0]            arsize, awsize;
    logic [1:0]            arburst, awburst, rresp, bresp, presp;
    logic                  arvalid, arready, rlast, rvalid, rready;
    logic                  awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [axi_data_w-1:0] rdata, wdata;
    logic [strb_w-1:0]     wstrb;
    logic                  psel, penable, pwrite, pready;
    logic [apb_data_w-1:0] pwdata, prdata;
    logic [apb_strb_w-1:0] pstrb;

    logic [31:0] apb_mem [bit [31:0]];
    logic [31:0] shadow [bit [31:0]];
    r_beat_t     r_exp [$];
    b_resp_t     b_exp [$];
    logic [31:0] data_state, wait_state, ready_state;
    int          wait_left;
    int          errors;
    int          checks;
    bit          throttle;
    string       test_name;

    axi2apb_bridge axi2apb_bridge_i (.*);

    function automatic logic [31:0] lcg_step(inout logic [31:0] s);
        s = s * 32'd1103515245 + 32'd12345;
        return s;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address of beat n, walked from the aligned start address
    function automatic logic [31:0] ref_beat_addr(input logic [31:0] start, input logic [7:0] len,
                                                  input logic [1:0] burst, input int n);
        logic [31:0] a;
        logic [31:0] window;
        logic [31:0] base;
        a      = {start[31:3], 3'b000};
        window = (32'(len) + 32'd1) * 32'd8;
        base   = (a / window) * window;
        for (int i = 0; i < n; i++) begin
            if (burst == burst_incr) begin
                a = a + 32'd8;
            end else if (burst == burst_wrap) begin
                a = base + ((a - base + 32'd8) % window);
            end
        end
        return a;
    endfunction

    function automatic void shadow_write(input logic [31:0] a, input logic [63:0] d,
                                         input logic [7:0] strb);
        logic [31:0] word;
        logic [31:0] wa;
        for (int w = 0; w < 2; w++) begin
            wa   = a + 32'(w * 4);
            word = shadow_word(wa);
            for (int b = 0; b < 4; b++) begin
                if (strb[w*4+b]) begin
                    word[b*8 +: 8] = d[w*32+b*8 +: 8];
                end
            end
            // The erroring word is never written by the slave
            if (wa != err_addr) begin
                shadow[wa] = word;
            end
        end
    endfunction

    task automatic compare_field(input string field, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI master driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                               input logic [7:0] len, input logic [1:0] burst,
                               input logic [7:0] strb);
        logic [63:0] d;
        logic [31:0] a;
        logic        err;
        err = 1'b0;
        @(negedge clk);
        {awid, awaddr, awlen, awburst} = {id, addr, len, burst};
        awvalid = 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            a        = ref_beat_addr(addr, len, burst, n);
            d[31:0]  = lcg_step(data_state);
            d[63:32] = lcg_step(data_state);
            if (a == err_addr || a + 32'd4 == err_addr) begin
                err = 1'b1;
            end
            shadow_write(a, d, strb);
            {wdata, wstrb, wlast} = {d, strb, n == int'(len)};
            wvalid = 1'b1;
            @(posedge clk);
            while (!wready) @(posedge clk);
            @(negedge clk);
            wvalid = 1'b0;
        end
        b_exp.push_back({id, err ? resp_slverr : resp_okay});
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [1:0] burst);
        logic [31:0] a;
        for (int n = 0; n <= int'(len); n++) begin
            a = ref_beat_addr(addr, len, burst, n);
            // Beat response follows the high word transfer
            r_exp.push_back({id, shadow_word(a + 32'd4), shadow_word(a),
                             (a + 32'd4 == err_addr) ? resp_slverr : resp_okay,
                             n == int'(len)});
        end
        @(negedge clk);
        {arid, araddr, arlen, arburst} = {id, addr, len, burst};
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic drain();
        while (r_exp.size() != 0 || b_exp.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB slave model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        logic [31:0] word;
        pready = 1'b0;
        presp  = resp_okay;
        if (psel && !penable) begin
            wait_left = int'((lcg_step(wait_state) >> 16) % 3);
        end else if (psel && penable && wait_left > 0) begin
            wait_left = wait_left - 1;
        end else if (psel && penable) begin
            word   = apb_mem.exists(paddr) ? apb_mem[paddr] : fill_word(paddr);
            pready = 1'b1;
            prdata = word;
            // Reads carry no byte strobes
            if (!pwrite) begin
                compare_field("pstrb", 64'd0, 64'(pstrb));
            end
            if (paddr == err_addr) begin
                presp = resp_slverr;
            end else if (pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (pstrb[b]) begin
                        word[b*8 +: 8] = pwdata[b*8 +: 8];
                    end
                end
                apb_mem[paddr] = word;
            end
        end
    end

    // Random R and B back-pressure
    always @(negedge clk) begin
        logic [31:0] r;
        if (throttle) begin
            r      = lcg_step(ready_state);
            rready = r[20];
            bready = r[27];
        end
    end

    always @(posedge clk) begin
        r_beat_t er;
        b_resp_t eb;
        if (rst_n && rvalid && rready) begin
            if (r_exp.size() == 0) begin
                errors++;
                $display("%s: read beat with rid %0h arrived with none expected", test_name, rid);
            end else begin
                er = r_exp.pop_front();
                compare_field("rid", 64'(er.id), 64'(rid));
                compare_field("rdata", er.data, rdata);
                compare_field("rresp", 64'(er.resp), 64'(rresp));
                compare_field("rlast", 64'(er.last), 64'(rlast));
            end
        end
        if (rst_n && bvalid && bready) begin
            if (b_exp.size() == 0) begin
                errors++;
                $display("%s: write response with bid %0h arrived with none expected",
                         test_name, bid);
            end else begin
                eb = b_exp.pop_front();
                compare_field("bid", 64'(eb.id), 64'(bid));
                compare_field("bresp", 64'(eb.resp), 64'(bresp));
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (test_beats * 200 + 10) @(posedge clk);
        $display("timeout with %0d read beats and %0d write responses outstanding",
                 r_exp.size(), b_exp.size());
        $display("test failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        {arid, araddr, arlen, arburst, arvalid} = '0;
        {awid, awaddr, awlen, awburst, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid} = '0;
        {pready, presp, prdata} = '0;
        arsize      = 3'd3;
        awsize      = 3'd3;
        rready      = 1'b1;
        bready      = 1'b1;
        data_state  = lcg_seed;
        wait_state  = lcg_seed + 32'd1;
        ready_state = lcg_seed + 32'd2;
        {wait_left, errors, checks, throttle} = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset";
        compare_field("idle outputs", 64'd0, 64'({psel, penable, pwrite, rvalid, bvalid}));
        compare_field("readies", 64'h7, 64'({arready, awready, wready}));

        test_name = "incr_write_read";
        write_burst(4'h3, 32'h0000_0000, 8'd3, burst_incr, 8'hFF);
        drain();
        read_burst(4'h5, 32'h0000_0000, 8'd3, burst_incr);
        drain();

        test_name = "fixed_write";
        write_burst(4'h4, 32'h0000_0100, 8'd2, burst_fixed, 8'hFF);
        drain();
        read_burst(4'h4, 32'h0000_0100, 8'd0, burst_incr);
        drain();

        test_name = "wrap_read";
        read_burst(4'h6, 32'h0000_0310, 8'd3, burst_wrap);
        drain();

        test_name = "partial_strobe";
        write_burst(4'h2, 32'h0000_0000, 8'd1, burst_incr, 8'h5A);
        drain();
        read_burst(4'h1, 32'h0000_0000, 8'd1, burst_incr);
        drain();

        test_name = "slverr";
        write_burst(4'h7, 32'h0000_01F0, 8'd3, burst_incr, 8'hFF);
        drain();
        read_burst(4'h8, 32'h0000_01F0, 8'd3, burst_incr);
        drain();

        test_name = "mixed_backpressure";
        throttle  = 1'b1;
        for (int k = 0; k < 3; k++) begin
            write_burst(4'(9 + k), 32'h0000_0400 + 32'(k * 16), 8'd1, burst_incr, 8'hFF);
            read_burst(4'(12 + k), 32'(k * 16), 8'd1, burst_incr);
        end
        drain();
        @(negedge clk);
        throttle = 1'b0;
        rready   = 1'b1;
        bready   = 1'b1;

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
axi2apb_pkg.sv
bridge_fifo.sv
bridge_ifs.sv
axi_req_capture.sv
apb_beat_engine.sv
axi_resp_queue.sv
axi2apb_bridge.sv
axi2apb_asserts.sv
tb_axi2apb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_axi2apb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
